/* bypass_stream_pkg.sv */
package bypass_stream_pkg;

    // --------------------------------------------------
    // stream geometry.
    // --------------------------------------------------
    localparam int data_width = 64;
    localparam int keep_width = 8;

    // source ports of the card, carried on tid.
    typedef enum logic [1:0] {
        cmac_port0 = 2'd0,
        cmac_port1 = 2'd1,
        host_port0 = 2'd2,
        host_port1 = 2'd3
    } port_t;

    // destination code, carried on tdest.
    typedef logic [1:0] tdest_t;

    // switch DROP code point seen at ingress.
    localparam tdest_t tdest_drop = 2'd3;

    // --------------------------------------------------
    // beat FIFO sizing.
    // --------------------------------------------------
    localparam int fifo_depth = 16;
    localparam int fifo_ptr_width = $clog2(fifo_depth);

    typedef logic [fifo_ptr_width:0] fifo_count_t;

    // one stored beat.
    typedef struct packed {
        logic [data_width-1:0] tdata;
        logic [keep_width-1:0] tkeep;
        logic                  tlast;
        port_t                 tid;
        tdest_t                tdest;
    } beat_t;

    // rule applied by a packet drop stage.
    typedef enum logic {
        drop_on_code,
        drop_on_loop
    } drop_mode_t;

endpackage

/* bypass_reg_pkg.sv */
package bypass_reg_pkg;

    // register opcodes on reg_addr.
    typedef enum logic [2:0] {
        reg_ctrl       = 3'd0,
        reg_map0       = 3'd1,
        reg_map1       = 3'd2,
        reg_map2       = 3'd3,
        reg_map3       = 3'd4,
        reg_igr_drops  = 3'd5,
        reg_loop_drops = 3'd6
    } reg_addr_t;

    // --------------------------------------------------
    // field layout.
    // --------------------------------------------------
    localparam int reg_data_width = 16;

    // bit positions inside reg_ctrl.
    localparam int ctrl_igr_drop_bit  = 0;
    localparam int ctrl_loop_drop_bit = 1;

    // dropped-packet counters wrap at this width.
    localparam int cnt_width = 16;

endpackage

/* axis_stream_if.sv */
`timescale 1ns/100ps

interface axis_stream_if (
    input logic core_clk,
    input logic rst_n
);
    import bypass_stream_pkg::*;

    logic                  tvalid;
    logic                  tready;
    logic [data_width-1:0] tdata;
    logic [keep_width-1:0] tkeep;
    logic                  tlast;
    port_t                 tid;
    tdest_t                tdest;

    modport source (
        output tvalid, tdata, tkeep, tlast, tid, tdest,
        input  tready
    );

    modport sink (
        input  tvalid, tdata, tkeep, tlast, tid, tdest,
        output tready
    );

    // a stalled beat keeps its payload until it transfers.
    a_payload_stable: assert property (@(posedge core_clk) disable iff (!rst_n)
        tvalid && !tready |=> $stable({tdata, tkeep, tlast, tid, tdest}));

endinterface

/* pkt_drop.sv */
`timescale 1ns/100ps

module pkt_drop #(
    parameter bypass_stream_pkg::drop_mode_t mode = bypass_stream_pkg::drop_on_code
) (
    input  logic                                 core_clk,
    input  logic                                 rst_n,
    axis_stream_if.sink                          in_s,
    axis_stream_if.source                        out_s,
    input  logic                                 drop_en,
    output logic [bypass_reg_pkg::cnt_width-1:0] drop_count
);
    import bypass_stream_pkg::*;

    logic sop;
    logic dropping;
    logic rule_hit;
    logic drop_now;
    logic xfer;

    // drop rule, looked at only on the first beat.
    always_comb begin
        if (mode == drop_on_code) begin
            rule_hit = (in_s.tdest == tdest_drop);
        end else begin
            rule_hit = (in_s.tdest == tdest_t'(in_s.tid));
        end
    end

    assign drop_now = sop ? (rule_hit && drop_en) : dropping;

    // dropped beats are swallowed here whatever the output does.
    assign in_s.tready = drop_now || out_s.tready;
    assign xfer        = in_s.tvalid && in_s.tready;

    // --------------------------------------------------
    // kept packets pass straight through.
    // --------------------------------------------------
    assign out_s.tvalid = in_s.tvalid && !drop_now;
    assign out_s.tdata  = in_s.tdata;
    assign out_s.tkeep  = in_s.tkeep;
    assign out_s.tlast  = in_s.tlast;
    assign out_s.tid    = in_s.tid;
    assign out_s.tdest  = in_s.tdest;

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            sop        <= 1'b1;
            dropping   <= 1'b0;
            drop_count <= '0;
        end else if (xfer) begin
            sop      <= in_s.tlast;
            dropping <= drop_now && !in_s.tlast;
            // one count per packet, taken on its first beat.
            if (sop && drop_now) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

endmodule

/* pkt_fifo.sv */
`timescale 1ns/100ps

module pkt_fifo (
    input logic           core_clk,
    input logic           rst_n,
    axis_stream_if.sink   in_s,
    axis_stream_if.source out_s
);
    import bypass_stream_pkg::*;

    beat_t mem [fifo_depth];
    beat_t out_q;

    logic [fifo_ptr_width-1:0] wr_ptr;
    logic [fifo_ptr_width-1:0] rd_ptr;
    fifo_count_t               count;
    logic                      out_valid;

    logic push;
    logic pop;
    logic load;
    logic mem_empty;
    logic bypass;
    logic mem_wr;
    logic mem_rd;

    // --------------------------------------------------
    // flow control.
    // --------------------------------------------------
    assign in_s.tready = (count != fifo_count_t'(fifo_depth));
    assign push        = in_s.tvalid && in_s.tready;
    assign pop         = out_valid && out_s.tready;

    // output register can take a beat when empty or draining.
    assign load      = !out_valid || pop;
    assign mem_empty = (count == '0);
    // an empty FIFO hands the beat directly to the output register.
    assign bypass    = push && load && mem_empty;
    assign mem_wr    = push && !bypass;
    assign mem_rd    = load && !mem_empty;

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (mem_wr && !mem_rd) begin
                count <= count + 1'b1;
            end else if (mem_rd && !mem_wr) begin
                count <= count - 1'b1;
            end
            if (load) begin
                out_valid <= mem_rd || bypass;
            end
        end
    end

    // storage and output beat.
    always_ff @(posedge core_clk) begin
        if (mem_wr) begin
            mem[wr_ptr] <= '{in_s.tdata, in_s.tkeep, in_s.tlast, in_s.tid, in_s.tdest};
        end
        if (mem_rd) begin
            out_q <= mem[rd_ptr];
        end else if (bypass) begin
            out_q <= '{in_s.tdata, in_s.tkeep, in_s.tlast, in_s.tid, in_s.tdest};
        end
    end

    assign out_s.tvalid = out_valid;
    assign out_s.tdata  = out_q.tdata;
    assign out_s.tkeep  = out_q.tkeep;
    assign out_s.tlast  = out_q.tlast;
    assign out_s.tid    = out_q.tid;
    assign out_s.tdest  = out_q.tdest;

    // a write never lands on the unread head of a full memory.
    a_no_write_full: assert property (@(posedge core_clk) disable iff (!rst_n)
        mem_wr && count != '0 |-> wr_ptr != rd_ptr);

    // a read never runs past the last written slot.
    a_no_read_empty: assert property (@(posedge core_clk) disable iff (!rst_n)
        mem_rd && count != fifo_count_t'(fifo_depth) |-> wr_ptr != rd_ptr);

endmodule

/* tdest_remap.sv */
`timescale 1ns/100ps

module tdest_remap (
    input logic                            core_clk,
    input logic                            rst_n,
    axis_stream_if.sink                    in_s,
    axis_stream_if.source                  out_s,
    input bypass_stream_pkg::tdest_t [3:0] tdest_map
);
    import bypass_stream_pkg::*;

    logic                  valid_q;
    logic                  sop;
    logic                  load;
    logic [data_width-1:0] data_q;
    logic [keep_width-1:0] keep_q;
    logic                  last_q;
    port_t                 tid_q;
    tdest_t                tdest_q;

    // one-deep stage.
    assign in_s.tready = !valid_q || out_s.tready;
    assign load        = in_s.tvalid && in_s.tready;

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            sop     <= 1'b1;
        end else begin
            if (in_s.tready) begin
                valid_q <= in_s.tvalid;
            end
            if (load) begin
                sop <= in_s.tlast;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (load) begin
            data_q <= in_s.tdata;
            keep_q <= in_s.tkeep;
            last_q <= in_s.tlast;
            tid_q  <= in_s.tid;
            // the incoming tdest is replaced, and the new one holds for the packet.
            if (sop) begin
                tdest_q <= tdest_map[in_s.tid];
            end
        end
    end

    assign out_s.tvalid = valid_q;
    assign out_s.tdata  = data_q;
    assign out_s.tkeep  = keep_q;
    assign out_s.tlast  = last_q;
    assign out_s.tid    = tid_q;
    assign out_s.tdest  = tdest_q;

endmodule

/* bypass_regs.sv */
`timescale 1ns/100ps

module bypass_regs (
    input  logic                                      core_clk,
    input  logic                                      rst_n,
    input  logic                                      reg_wr,
    input  logic                                      reg_rd,
    input  bypass_reg_pkg::reg_addr_t                 reg_addr,
    input  logic [bypass_reg_pkg::reg_data_width-1:0] reg_wdata,
    output logic [bypass_reg_pkg::reg_data_width-1:0] reg_rdata,
    output logic                                      reg_rvalid,
    output logic                                      igr_drop_en,
    output logic                                      loop_drop_en,
    output bypass_stream_pkg::tdest_t [3:0]           tdest_map,
    input  logic [bypass_reg_pkg::cnt_width-1:0]      igr_drop_count,
    input  logic [bypass_reg_pkg::cnt_width-1:0]      loop_drop_count
);
    import bypass_reg_pkg::*;

    logic [reg_data_width-1:0] rd_mux;

    // --------------------------------------------------
    // write decode.
    // --------------------------------------------------
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            igr_drop_en  <= 1'b0;
            loop_drop_en <= 1'b0;
            tdest_map    <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                reg_ctrl: begin
                    igr_drop_en  <= reg_wdata[ctrl_igr_drop_bit];
                    loop_drop_en <= reg_wdata[ctrl_loop_drop_bit];
                end
                reg_map0: tdest_map[0] <= reg_wdata[1:0];
                reg_map1: tdest_map[1] <= reg_wdata[1:0];
                reg_map2: tdest_map[2] <= reg_wdata[1:0];
                reg_map3: tdest_map[3] <= reg_wdata[1:0];
                // counters are read-only.
                default: ;
            endcase
        end
    end

    // --------------------------------------------------
    // read path, one cycle after the strobe.
    // --------------------------------------------------
    always_comb begin
        case (reg_addr)
            reg_ctrl:       rd_mux = reg_data_width'({loop_drop_en, igr_drop_en});
            reg_map0:       rd_mux = reg_data_width'(tdest_map[0]);
            reg_map1:       rd_mux = reg_data_width'(tdest_map[1]);
            reg_map2:       rd_mux = reg_data_width'(tdest_map[2]);
            reg_map3:       rd_mux = reg_data_width'(tdest_map[3]);
            reg_igr_drops:  rd_mux = reg_data_width'(igr_drop_count);
            reg_loop_drops: rd_mux = reg_data_width'(loop_drop_count);
            default:        rd_mux = '0;
        endcase
    end

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge core_clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

    a_no_rd_wr_overlap: assert property (@(posedge core_clk) disable iff (!rst_n)
        !(reg_wr && reg_rd));

endmodule

/* smartnic_bypass.sv */
`timescale 1ns/100ps

module smartnic_bypass (
    input  logic                                          core_clk,
    input  logic                                          rst_n,
    input  logic                                          in_tvalid,
    output logic                                          in_tready,
    input  logic [bypass_stream_pkg::data_width-1:0]      in_tdata,
    input  logic [bypass_stream_pkg::keep_width-1:0]      in_tkeep,
    input  logic                                          in_tlast,
    input  bypass_stream_pkg::port_t                      in_tid,
    input  bypass_stream_pkg::tdest_t                     in_tdest,
    output logic                                          out_tvalid,
    input  logic                                          out_tready,
    output logic [bypass_stream_pkg::data_width-1:0]      out_tdata,
    output logic [bypass_stream_pkg::keep_width-1:0]      out_tkeep,
    output logic                                          out_tlast,
    output bypass_stream_pkg::port_t                      out_tid,
    output bypass_stream_pkg::tdest_t                     out_tdest,
    input  logic                                          reg_wr,
    input  logic                                          reg_rd,
    input  bypass_reg_pkg::reg_addr_t                     reg_addr,
    input  logic [bypass_reg_pkg::reg_data_width-1:0]     reg_wdata,
    output logic [bypass_reg_pkg::reg_data_width-1:0]     reg_rdata,
    output logic                                          reg_rvalid
);
    import bypass_stream_pkg::*;
    import bypass_reg_pkg::*;

    logic                 igr_drop_en;
    logic                 loop_drop_en;
    tdest_t [3:0]         tdest_map;
    logic [cnt_width-1:0] igr_drop_count;
    logic [cnt_width-1:0] loop_drop_count;

    // --------------------------------------------------
    // stream hops along the bypass path.
    // --------------------------------------------------
    axis_stream_if s_in       (.core_clk(core_clk), .rst_n(rst_n));
    axis_stream_if s_fifo_in  (.core_clk(core_clk), .rst_n(rst_n));
    axis_stream_if s_fifo_out (.core_clk(core_clk), .rst_n(rst_n));
    axis_stream_if s_loop_in  (.core_clk(core_clk), .rst_n(rst_n));
    axis_stream_if s_out      (.core_clk(core_clk), .rst_n(rst_n));

    assign s_in.tvalid = in_tvalid;
    assign s_in.tdata  = in_tdata;
    assign s_in.tkeep  = in_tkeep;
    assign s_in.tlast  = in_tlast;
    assign s_in.tid    = in_tid;
    assign s_in.tdest  = in_tdest;
    assign in_tready   = s_in.tready;

    assign out_tvalid   = s_out.tvalid;
    assign out_tdata    = s_out.tdata;
    assign out_tkeep    = s_out.tkeep;
    assign out_tlast    = s_out.tlast;
    assign out_tid      = s_out.tid;
    assign out_tdest    = s_out.tdest;
    assign s_out.tready = out_tready;

    // ingress switch drop of the DROP code point.
    pkt_drop #(.mode(drop_on_code)) igr_drop (
        .core_clk   (core_clk),
        .rst_n      (rst_n),
        .in_s       (s_in),
        .out_s      (s_fifo_in),
        .drop_en    (igr_drop_en),
        .drop_count (igr_drop_count)
    );

    pkt_fifo bypass_fifo (
        .core_clk (core_clk),
        .rst_n    (rst_n),
        .in_s     (s_fifo_in),
        .out_s    (s_fifo_out)
    );

    tdest_remap bypass_remap (
        .core_clk  (core_clk),
        .rst_n     (rst_n),
        .in_s      (s_fifo_out),
        .out_s     (s_loop_in),
        .tdest_map (tdest_map)
    );

    // loop drop, so a packet never returns to its own port.
    pkt_drop #(.mode(drop_on_loop)) loop_drop (
        .core_clk   (core_clk),
        .rst_n      (rst_n),
        .in_s       (s_loop_in),
        .out_s      (s_out),
        .drop_en    (loop_drop_en),
        .drop_count (loop_drop_count)
    );

    bypass_regs regs (
        .core_clk        (core_clk),
        .rst_n           (rst_n),
        .reg_wr          (reg_wr),
        .reg_rd          (reg_rd),
        .reg_addr        (reg_addr),
        .reg_wdata       (reg_wdata),
        .reg_rdata       (reg_rdata),
        .reg_rvalid      (reg_rvalid),
        .igr_drop_en     (igr_drop_en),
        .loop_drop_en    (loop_drop_en),
        .tdest_map       (tdest_map),
        .igr_drop_count  (igr_drop_count),
        .loop_drop_count (loop_drop_count)
    );

endmodule

/* tb_smartnic_bypass.sv */
`timescale 1ns/100ps

module tb_smartnic_bypass;
    import bypass_stream_pkg::*;
    import bypass_reg_pkg::*;

    typedef logic [8*16-1:0] token_t;

    // one parsed line of the stimulus file.
    typedef struct packed {
        token_t cmd;
        token_t name;
        int     a;
        int     b;
        int     beats;
        int     exp_dest;
    } step_t;

    logic                      core_clk;
    logic                      rst_n;
    logic                      in_tvalid;
    logic                      in_tready;
    logic [data_width-1:0]     in_tdata;
    logic [keep_width-1:0]     in_tkeep;
    logic                      in_tlast;
    port_t                     in_tid;
    tdest_t                    in_tdest;
    logic                      out_tvalid;
    logic                      out_tready;
    logic [data_width-1:0]     out_tdata;
    logic [keep_width-1:0]     out_tkeep;
    logic                      out_tlast;
    port_t                     out_tid;
    tdest_t                    out_tdest;
    logic                      reg_wr;
    logic                      reg_rd;
    reg_addr_t                 reg_addr;
    logic [reg_data_width-1:0] reg_wdata;
    logic [reg_data_width-1:0] reg_rdata;
    logic                      reg_rvalid;

    step_t  step_q [$];
    beat_t  exp_q [$];
    token_t exp_name_q [$];

    int errors         = 0;
    int beats_checked  = 0;
    int cycle_count    = 0;
    int timeout_cycles = 0;
    int total_beats    = 0;

    smartnic_bypass smartnic_bypass_inst (.*);

    always #50 core_clk = ~core_clk;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_run();
        if (exp_q.size() != 0) begin
            $display("%0d expected output beats never arrived", exp_q.size());
            errors++;
        end
        $display("errors: %0d, beats checked: %0d", errors, beats_checked);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    // --------------------------------------------------
    // stimulus file parsing.
    // --------------------------------------------------
    task automatic load_stimulus(output bit ok);
        int               fd;
        int               n;
        token_t           tok;
        token_t           expect_tok;
        step_t            st;
        logic [8*128-1:0] line;
        fd = $fopen("bypass_stimulus.txt", "r");
        ok = (fd != 0);
        while (ok && !$feof(fd)) begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) begin
                break;
            end
            st = '0;
            st.cmd = tok;
            if (tok == token_t'("W") || tok == token_t'("R")) begin
                n = $fscanf(fd, "%d %d", st.a, st.b);
                if (n != 2) begin
                    $display("stimulus file has a broken register line");
                    errors++;
                end
                step_q.push_back(st);
            end else if (tok == token_t'("P")) begin
                n = $fscanf(fd, "%s %d %d %d %s", st.name, st.a, st.b, st.beats, expect_tok);
                if (n != 5) begin
                    $display("stimulus file has a broken packet line");
                    errors++;
                end
                // drop is kept as a negative tdest.
                st.exp_dest = (expect_tok == token_t'("drop")) ? -1
                                                              : int'(expect_tok[7:0]) - 48;
                total_beats += st.beats;
                step_q.push_back(st);
            end else begin
                n = $fgets(line, fd);
            end
        end
        if (ok) begin
            $fclose(fd);
        end
    endtask

    // --------------------------------------------------
    // drivers.
    // --------------------------------------------------
    task automatic send_packet(input step_t st);
        beat_t beat;
        for (int i = 0; i < st.beats; i++) begin
            beat.tdata = {$urandom, $urandom};
            beat.tlast = (i == st.beats - 1);
            beat.tkeep = beat.tlast ? (8'hff >> ($urandom % 8)) : 8'hff;
            beat.tid   = port_t'(st.a[1:0]);
            beat.tdest = tdest_t'(st.exp_dest[1:0]);
            if (st.exp_dest >= 0) begin
                exp_q.push_back(beat);
                exp_name_q.push_back(st.name);
            end
            in_tvalid = 1'b1;
            in_tdata  = beat.tdata;
            in_tkeep  = beat.tkeep;
            in_tlast  = beat.tlast;
            in_tid    = beat.tid;
            in_tdest  = tdest_t'(st.b[1:0]);
            @(posedge core_clk);
            while (!in_tready) begin
                @(posedge core_clk);
            end
            #1;
        end
        in_tvalid = 1'b0;
    endtask

    task automatic write_reg(input int addr, input int data);
        reg_addr  = reg_addr_t'(addr[2:0]);
        reg_wdata = data[reg_data_width-1:0];
        reg_wr    = 1'b1;
        @(posedge core_clk);
        #1;
        reg_wr = 1'b0;
    endtask

    task automatic read_reg(input int addr, input int expected);
        reg_addr = reg_addr_t'(addr[2:0]);
        reg_rd   = 1'b1;
        @(posedge core_clk);
        #1;
        reg_rd = 1'b0;
        @(posedge core_clk);
        while (!reg_rvalid) begin
            @(posedge core_clk);
        end
        check_value($sformatf("reg read addr %0d", addr), 64'(expected), 64'(reg_rdata));
        #1;
    endtask

    // every packet sent so far has left the DUT.
    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge core_clk);
        end
        @(posedge core_clk);
        #1;
    endtask

    // output monitor.
    initial begin
        beat_t exp_beat;
        string nm;
        forever begin
            @(posedge core_clk);
            if (rst_n && out_tvalid && out_tready) begin
                if (exp_q.size() == 0) begin
                    $display("output beat from tid %0d arrived with nothing expected", out_tid);
                    errors++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    nm = string'(exp_name_q.pop_front());
                    check_value({nm, " tdata"}, exp_beat.tdata, out_tdata);
                    check_value({nm, " tkeep"}, 64'(exp_beat.tkeep), 64'(out_tkeep));
                    check_value({nm, " tlast"}, 64'(exp_beat.tlast), 64'(out_tlast));
                    check_value({nm, " tid"}, 64'(exp_beat.tid), 64'(out_tid));
                    check_value({nm, " tdest"}, 64'(exp_beat.tdest), 64'(out_tdest));
                    beats_checked++;
                end
            end
        end
    end

    // sink back-pressure, ready on about 70% of cycles.
    initial begin
        forever begin
            @(posedge core_clk);
            #1;
            out_tready = (($urandom % 10) < 7);
        end
    end

    initial begin
        while (timeout_cycles == 0 || cycle_count < timeout_cycles) begin
            @(posedge core_clk);
            cycle_count++;
        end
        $display("run timed out after %0d cycles", cycle_count);
        errors++;
        finish_run();
    end

    // --------------------------------------------------
    // main sequence.
    // --------------------------------------------------
    initial begin
        bit    ok;
        step_t st;
        void'($urandom(40));
        core_clk   = 1'b0;
        rst_n      = 1'b0;
        in_tvalid  = 1'b0;
        in_tdata   = '0;
        in_tkeep   = '0;
        in_tlast   = 1'b0;
        in_tid     = cmac_port0;
        in_tdest   = '0;
        out_tready = 1'b0;
        reg_wr     = 1'b0;
        reg_rd     = 1'b0;
        reg_addr   = reg_ctrl;
        reg_wdata  = '0;
        load_stimulus(ok);
        timeout_cycles = total_beats * 4 + 200;
        repeat (5) @(posedge core_clk);
        #1;
        rst_n = 1'b1;
        if (!ok) begin
            $display("could not open bypass_stimulus.txt");
            errors++;
        end else begin
            foreach (step_q[i]) begin
                st = step_q[i];
                if (st.cmd == token_t'("P")) begin
                    send_packet(st);
                end else begin
                    // config changes only once the pipeline is empty.
                    wait_drain();
                    if (st.cmd == token_t'("W")) begin
                        write_reg(st.a, st.b);
                    end else begin
                        read_reg(st.a, st.b);
                    end
                end
            end
            wait_drain();
        end
        finish_run();
    end

endmodule

/* bypass_stimulus.txt */
# columns: W addr data | R addr expected | P name tid tdest beats expect
# addr 0 ctrl and 1 to 4 map0 to map3 and 5 igr drops and 6 loop drops; expect is tdest or drop
R 0 0
P rst_p0 0 1 3 0
P rst_p1 1 3 1 0
P rst_h0 2 2 4 0
P rst_h1 3 3 2 0
W 0 1
R 0 1
P igr_keep0 0 1 2 0
P igr_drop0 1 3 3 drop
P igr_keep1 2 0 1 0
P igr_drop1 3 3 1 drop
P igr_keep2 1 2 5 0
R 5 2
W 1 2
W 2 3
W 3 1
W 4 0
P map_p0 0 0 1 2
P map_p1 1 2 4 3
P map_h0 2 3 3 drop
P map_h0b 2 1 2 1
P map_h1 3 0 1 0
R 1 2
R 4 0
W 2 1
W 0 2
P loop_p1a 1 0 2 drop
P loop_p0 0 3 2 2
P loop_p1b 1 1 1 drop
P loop_h1 3 2 3 0
R 6 2
W 0 0
P noloop_p1 1 0 3 1
R 6 2
R 5 3
W 0 3
P burst_a 0 1 20 2
P burst_b 2 3 18 drop
P burst_c 3 2 24 0
P burst_d 0 2 17 2
R 0 3
R 2 1
R 3 1
R 5 4
R 6 2

/* vlog.f */
bypass_stream_pkg.sv
bypass_reg_pkg.sv
axis_stream_if.sv
pkt_drop.sv
pkt_fifo.sv
tdest_remap.sv
bypass_regs.sv
smartnic_bypass.sv
tb_smartnic_bypass.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wall
TOP      = tb_smartnic_bypass
FILELIST = vlog.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)
LOG     := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) bypass_stimulus.txt
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
